/* rtl/id_pkg.sv */
`default_nettype none

package id_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int DATA_W     = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [7:0]            alu_op_t;
    typedef logic [2:0]            alu_sel_t;

    localparam reg_addr_t NOP_REG_ADDR = '0;

    // ------------------------------------------------------------------------
    // Primary opcodes, instruction bits 31:26
    // ------------------------------------------------------------------------
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // Function field of SPECIAL, bits 5:0
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_MOVZ = 6'b001010;
    localparam logic [5:0] FN_MOVN = 6'b001011;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // ------------------------------------------------------------------------
    // Operations handed to execute
    // ------------------------------------------------------------------------
    localparam alu_op_t ALU_NOP   = 8'b0000_0000;
    localparam alu_op_t ALU_SRL   = 8'b0000_0010;
    localparam alu_op_t ALU_SRA   = 8'b0000_0011;
    localparam alu_op_t ALU_MOVZ  = 8'b0000_1010;
    localparam alu_op_t ALU_MOVN  = 8'b0000_1011;
    localparam alu_op_t ALU_ADD   = 8'b0010_0000;
    localparam alu_op_t ALU_ADDU  = 8'b0010_0001;
    localparam alu_op_t ALU_SUB   = 8'b0010_0010;
    localparam alu_op_t ALU_SUBU  = 8'b0010_0011;
    localparam alu_op_t ALU_AND   = 8'b0010_0100;
    localparam alu_op_t ALU_OR    = 8'b0010_0101;
    localparam alu_op_t ALU_XOR   = 8'b0010_0110;
    localparam alu_op_t ALU_NOR   = 8'b0010_0111;
    localparam alu_op_t ALU_SLT   = 8'b0010_1010;
    localparam alu_op_t ALU_SLTU  = 8'b0010_1011;
    localparam alu_op_t ALU_ADDI  = 8'b0101_0101;
    localparam alu_op_t ALU_ADDIU = 8'b0101_0110;
    localparam alu_op_t ALU_SLL   = 8'b0111_1100;

    // Result class picks the execute output mux
    localparam alu_sel_t RES_NOP   = 3'b000;
    localparam alu_sel_t RES_LOGIC = 3'b001;
    localparam alu_sel_t RES_SHIFT = 3'b010;
    localparam alu_sel_t RES_MOVE  = 3'b011;
    localparam alu_sel_t RES_ARITH = 3'b100;

endpackage

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none

module reg_file
    import id_pkg::*;
(
    input  wire            clk,
    input  wire            reset_i,
    // Write port from writeback
    input  wire            we_i,
    input  wire reg_addr_t waddr_i,
    input  wire word_t     wdata_i,
    // Read ports steered by the decoder
    input  wire            re1_i,
    input  wire reg_addr_t raddr1_i,
    input  wire            re2_i,
    input  wire reg_addr_t raddr2_i,
    output word_t          rdata1_o,
    output word_t          rdata2_o
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != NOP_REG_ADDR)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Register zero is hardwired, a pending write shows up in the same cycle
    function automatic word_t read_port(input logic re, input reg_addr_t addr);
        word_t data;
        if (!re || (addr == NOP_REG_ADDR)) begin
            data = '0;
        end else if (we_i && (addr == waddr_i)) begin
            data = wdata_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rdata1_o = read_port(re1_i, raddr1_i);
    end

    always_comb begin
        rdata2_o = read_port(re2_i, raddr2_i);
    end

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`default_nettype none

module inst_decoder
    import id_pkg::*;
(
    input  wire            reset_i,
    input  wire inst_t     inst_i,
    // Second operand after forwarding, needed by MOVN and MOVZ
    input  wire word_t     rt_value_i,
    output alu_op_t        aluop_o,
    output alu_sel_t       alusel_o,
    output logic           reg1_read_o,
    output logic           reg2_read_o,
    output reg_addr_t      reg1_addr_o,
    output reg_addr_t      reg2_addr_o,
    output word_t          imm_o,
    output reg_addr_t      wd_o,
    output logic           wreg_o
);

    logic [5:0]  op;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  sa;
    logic [15:0] imm16;

    // Instruction format flags raised by the opcode case
    logic        rr_op;
    logic        shift_sa_op;
    logic        imm_op;
    logic        movn_sel;
    logic        movz_sel;
    logic        wreg_dec;

    assign op    = inst_i[31:26];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign sa    = inst_i[10:6];
    assign funct = inst_i[5:0];
    assign imm16 = inst_i[15:0];

    // ------------------------------------------------------------------------
    // Opcode and function decode
    // ------------------------------------------------------------------------
    always_comb begin
        aluop_o     = ALU_NOP;
        alusel_o    = RES_NOP;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        reg1_addr_o = rs;
        reg2_addr_o = rt;
        wd_o        = NOP_REG_ADDR;
        imm_o       = '0;
        wreg_dec    = 1'b0;
        rr_op       = 1'b0;
        shift_sa_op = 1'b0;
        imm_op      = 1'b0;
        movn_sel    = 1'b0;
        movz_sel    = 1'b0;

        if (reset_i) begin
            reg1_addr_o = NOP_REG_ADDR;
            reg2_addr_o = NOP_REG_ADDR;
        end else begin
            case (op)
                OP_SPECIAL: begin
                    // Shifts by sa need rs zero, the others need sa zero
                    if (rs == NOP_REG_ADDR) begin
                        case (funct)
                            FN_SLL: begin
                                aluop_o     = ALU_SLL;
                                shift_sa_op = 1'b1;
                            end
                            FN_SRL: begin
                                aluop_o     = ALU_SRL;
                                shift_sa_op = 1'b1;
                            end
                            FN_SRA: begin
                                aluop_o     = ALU_SRA;
                                shift_sa_op = 1'b1;
                            end
                            default: begin
                            end
                        endcase
                    end
                    if (sa == 5'd0) begin
                        rr_op = 1'b1;
                        case (funct)
                            FN_AND:  {aluop_o, alusel_o} = {ALU_AND, RES_LOGIC};
                            FN_OR:   {aluop_o, alusel_o} = {ALU_OR, RES_LOGIC};
                            FN_XOR:  {aluop_o, alusel_o} = {ALU_XOR, RES_LOGIC};
                            FN_NOR:  {aluop_o, alusel_o} = {ALU_NOR, RES_LOGIC};
                            FN_ADD:  {aluop_o, alusel_o} = {ALU_ADD, RES_ARITH};
                            FN_ADDU: {aluop_o, alusel_o} = {ALU_ADDU, RES_ARITH};
                            FN_SUB:  {aluop_o, alusel_o} = {ALU_SUB, RES_ARITH};
                            FN_SUBU: {aluop_o, alusel_o} = {ALU_SUBU, RES_ARITH};
                            FN_SLT:  {aluop_o, alusel_o} = {ALU_SLT, RES_ARITH};
                            FN_SLTU: {aluop_o, alusel_o} = {ALU_SLTU, RES_ARITH};
                            FN_SLLV: {aluop_o, alusel_o} = {ALU_SLL, RES_SHIFT};
                            FN_SRLV: {aluop_o, alusel_o} = {ALU_SRL, RES_SHIFT};
                            FN_SRAV: {aluop_o, alusel_o} = {ALU_SRA, RES_SHIFT};
                            FN_MOVN: begin
                                aluop_o  = ALU_MOVN;
                                alusel_o = RES_MOVE;
                                movn_sel = 1'b1;
                            end
                            FN_MOVZ: begin
                                aluop_o  = ALU_MOVZ;
                                alusel_o = RES_MOVE;
                                movz_sel = 1'b1;
                            end
                            default: rr_op = 1'b0;
                        endcase
                    end
                end
                OP_ADDI: begin
                    {aluop_o, alusel_o} = {ALU_ADDI, RES_ARITH};
                    imm_op = 1'b1;
                    imm_o  = {{(DATA_W-16){imm16[15]}}, imm16};
                end
                OP_ADDIU: begin
                    {aluop_o, alusel_o} = {ALU_ADDIU, RES_ARITH};
                    imm_op = 1'b1;
                    imm_o  = {{(DATA_W-16){imm16[15]}}, imm16};
                end
                OP_SLTI: begin
                    {aluop_o, alusel_o} = {ALU_SLT, RES_ARITH};
                    imm_op = 1'b1;
                    imm_o  = {{(DATA_W-16){imm16[15]}}, imm16};
                end
                OP_SLTIU: begin
                    {aluop_o, alusel_o} = {ALU_SLTU, RES_ARITH};
                    imm_op = 1'b1;
                    imm_o  = {{(DATA_W-16){imm16[15]}}, imm16};
                end
                OP_ANDI: begin
                    {aluop_o, alusel_o} = {ALU_AND, RES_LOGIC};
                    imm_op = 1'b1;
                    imm_o  = {{(DATA_W-16){1'b0}}, imm16};
                end
                OP_ORI: begin
                    {aluop_o, alusel_o} = {ALU_OR, RES_LOGIC};
                    imm_op = 1'b1;
                    imm_o  = {{(DATA_W-16){1'b0}}, imm16};
                end
                OP_XORI: begin
                    {aluop_o, alusel_o} = {ALU_XOR, RES_LOGIC};
                    imm_op = 1'b1;
                    imm_o  = {{(DATA_W-16){1'b0}}, imm16};
                end
                // LUI is an OR of rs with the upper-half immediate
                OP_LUI: begin
                    {aluop_o, alusel_o} = {ALU_OR, RES_LOGIC};
                    imm_op = 1'b1;
                    imm_o  = {imm16, {(DATA_W-16){1'b0}}};
                end
                default: begin
                end
            endcase

            if (shift_sa_op) begin
                alusel_o    = RES_SHIFT;
                reg2_read_o = 1'b1;
                imm_o       = word_t'(sa);
                wd_o        = rd;
                wreg_dec    = 1'b1;
            end
            if (rr_op) begin
                reg1_read_o = 1'b1;
                reg2_read_o = 1'b1;
                wd_o        = rd;
                wreg_dec    = !(movn_sel || movz_sel);
            end
            if (imm_op) begin
                reg1_read_o = 1'b1;
                wd_o        = rt;
                wreg_dec    = 1'b1;
            end
        end
    end

    // Conditional moves resolve on the forwarded rt value
    assign wreg_o = wreg_dec
                  | (movn_sel && (rt_value_i != '0))
                  | (movz_sel && (rt_value_i == '0));

endmodule

`default_nettype wire

/* rtl/operand_forward.sv */
`default_nettype none

module operand_forward
    import id_pkg::*;
(
    input  wire            read_i,
    input  wire reg_addr_t addr_i,
    input  wire word_t     rf_data_i,
    input  wire word_t     imm_i,
    // Result in flight in execute
    input  wire            ex_wreg_i,
    input  wire reg_addr_t ex_wd_i,
    input  wire word_t     ex_wdata_i,
    // Result in flight in memory
    input  wire            mem_wreg_i,
    input  wire reg_addr_t mem_wd_i,
    input  wire word_t     mem_wdata_i,
    output word_t          operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_wreg_i && (ex_wd_i == addr_i);
    assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i);

    // Youngest result wins
    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_wdata_i;
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
`default_nettype none

module id_stage
    import id_pkg::*;
(
    input  wire            clk,
    input  wire            reset_i,
    input  wire inst_t     inst_i,
    // Writeback into the register file
    input  wire            wb_we_i,
    input  wire reg_addr_t wb_addr_i,
    input  wire word_t     wb_data_i,
    // Forwarding from execute
    input  wire            ex_wreg_i,
    input  wire reg_addr_t ex_wd_i,
    input  wire word_t     ex_wdata_i,
    // Forwarding from memory
    input  wire            mem_wreg_i,
    input  wire reg_addr_t mem_wd_i,
    input  wire word_t     mem_wdata_i,
    // To execute
    output alu_op_t        aluop_o,
    output alu_sel_t       alusel_o,
    output word_t          reg1_o,
    output word_t          reg2_o,
    output reg_addr_t      wd_o,
    output logic           wreg_o
);

    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    word_t     rf_data1;
    word_t     rf_data2;
    word_t     imm;

    reg_file u_reg_file (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .re1_i    (reg1_read),
        .raddr1_i (reg1_addr),
        .re2_i    (reg2_read),
        .raddr2_i (reg2_addr),
        .rdata1_o (rf_data1),
        .rdata2_o (rf_data2)
    );

    inst_decoder u_decoder (
        .reset_i     (reset_i),
        .inst_i      (inst_i),
        .rt_value_i  (reg2_o),
        .aluop_o     (aluop_o),
        .alusel_o    (alusel_o),
        .reg1_read_o (reg1_read),
        .reg2_read_o (reg2_read),
        .reg1_addr_o (reg1_addr),
        .reg2_addr_o (reg2_addr),
        .imm_o       (imm),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o)
    );

    // ------------------------------------------------------------------------
    // Operand selection, rs side and rt side
    // ------------------------------------------------------------------------
    operand_forward u_fwd_a (
        .read_i      (reg1_read),
        .addr_i      (reg1_addr),
        .rf_data_i   (rf_data1),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg1_o)
    );

    operand_forward u_fwd_b (
        .read_i      (reg2_read),
        .addr_i      (reg2_addr),
        .rf_data_i   (rf_data2),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg2_o)
    );

endmodule

`default_nettype wire

/* testbench/id_tests.svh */
`ifndef ID_TESTS_SVH
`define ID_TESTS_SVH

    task automatic check_reg_reg(input string tag, input logic [5:0] funct,
                                 input alu_op_t exp_op, input alu_sel_t exp_sel,
                                 input reg_addr_t rs, input reg_addr_t rt, input reg_addr_t rd);
        apply_inst(r_format(rs, rt, rd, 5'd0, funct));
        check_outputs(tag, exp_op, exp_sel, rd, 1'b1, expected_operand(rs), expected_operand(rt));
    endtask

    task automatic check_imm(input string tag, input logic [5:0] op, input logic [15:0] imm,
                             input alu_op_t exp_op, input alu_sel_t exp_sel,
                             input word_t exp_imm);
        apply_inst(i_format(op, 5'd3, 5'd20, imm));
        check_outputs(tag, exp_op, exp_sel, 5'd20, 1'b1, expected_operand(5'd3), exp_imm);
    endtask

    task automatic check_shift_sa(input string tag, input logic [5:0] funct,
                                  input alu_op_t exp_op, input reg_addr_t rt,
                                  input reg_addr_t rd, input logic [4:0] sa);
        apply_inst(r_format(NOP_REG_ADDR, rt, rd, sa, funct));
        check_outputs(tag, exp_op, RES_SHIFT, rd, 1'b1, {27'd0, sa}, expected_operand(rt));
    endtask

    // Call right after the instruction is issued
    task automatic check_move(input string tag, input logic is_movn,
                              input reg_addr_t rs, input reg_addr_t rt, input reg_addr_t rd);
        word_t rt_val;
        rt_val = expected_operand(rt);
        check_outputs(tag, is_movn ? ALU_MOVN : ALU_MOVZ, RES_MOVE, rd,
                      is_movn ? (rt_val != '0) : (rt_val == '0),
                      expected_operand(rs), rt_val);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic reset_behavior();
        word_t fwd_data;
        start_test();
        // Forwarding is live during reset, operands must still be zero
        for (int i = 0; i < RESET_CYCLES; i++) begin
            fwd_data = $random(seed);
            issue($random(seed), 1'b1, reg_addr_t'(i), fwd_data,
                  1'b1, reg_addr_t'(i + 1), ~fwd_data);
            check_outputs("in reset", ALU_NOP, RES_NOP, NOP_REG_ADDR, 1'b0, '0, '0);
        end
        @(posedge clk);
        reset_i    <= 1'b0;
        ex_wreg_i  <= 1'b0;
        mem_wreg_i <= 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int k = 0; k < 16; k++) begin
            apply_inst(r_format(reg_addr_t'(2 * k + 1), reg_addr_t'(2 * k + 2), 5'd1, 5'd0, FN_OR));
            check_outputs("cleared regs", ALU_OR, RES_LOGIC, 5'd1, 1'b1, '0, '0);
        end
        report_test("reset_behavior");
    endtask

    task automatic reg_reg_ops();
        start_test();
        for (int r = 1; r <= 6; r++) begin
            write_reg(reg_addr_t'(r), $random(seed));
        end
        write_reg(NOP_REG_ADDR, 32'hdead_beef);
        check_reg_reg("and", FN_AND, ALU_AND, RES_LOGIC, 5'd1, 5'd2, 5'd7);
        check_reg_reg("or", FN_OR, ALU_OR, RES_LOGIC, 5'd2, 5'd3, 5'd8);
        check_reg_reg("xor", FN_XOR, ALU_XOR, RES_LOGIC, 5'd3, 5'd4, 5'd9);
        check_reg_reg("nor", FN_NOR, ALU_NOR, RES_LOGIC, 5'd4, 5'd5, 5'd10);
        check_reg_reg("add", FN_ADD, ALU_ADD, RES_ARITH, 5'd5, 5'd6, 5'd11);
        check_reg_reg("addu", FN_ADDU, ALU_ADDU, RES_ARITH, 5'd6, 5'd1, 5'd12);
        check_reg_reg("sub", FN_SUB, ALU_SUB, RES_ARITH, 5'd1, 5'd3, 5'd13);
        check_reg_reg("subu", FN_SUBU, ALU_SUBU, RES_ARITH, 5'd2, 5'd4, 5'd14);
        check_reg_reg("slt", FN_SLT, ALU_SLT, RES_ARITH, 5'd3, 5'd5, 5'd15);
        check_reg_reg("sltu", FN_SLTU, ALU_SLTU, RES_ARITH, 5'd4, 5'd6, 5'd16);
        // Register zero ignored the write above
        apply_inst(r_format(NOP_REG_ADDR, 5'd1, 5'd17, 5'd0, FN_OR));
        check_outputs("r0 read", ALU_OR, RES_LOGIC, 5'd17, 1'b1, '0, expected_operand(5'd1));
        report_test("reg_reg_ops");
    endtask

    task automatic immediate_ops();
        start_test();
        check_imm("addi", OP_ADDI, 16'h8001, ALU_ADDI, RES_ARITH, 32'hffff_8001);
        check_imm("addiu", OP_ADDIU, 16'h7ffe, ALU_ADDIU, RES_ARITH, 32'h0000_7ffe);
        check_imm("slti", OP_SLTI, 16'hfff0, ALU_SLT, RES_ARITH, 32'hffff_fff0);
        check_imm("sltiu", OP_SLTIU, 16'h8000, ALU_SLTU, RES_ARITH, 32'hffff_8000);
        check_imm("ori", OP_ORI, 16'h8421, ALU_OR, RES_LOGIC, 32'h0000_8421);
        check_imm("andi", OP_ANDI, 16'hf0f0, ALU_AND, RES_LOGIC, 32'h0000_f0f0);
        check_imm("xori", OP_XORI, 16'hffff, ALU_XOR, RES_LOGIC, 32'h0000_ffff);
        check_imm("lui", OP_LUI, 16'h1234, ALU_OR, RES_LOGIC, 32'h1234_0000);
        report_test("immediate_ops");
    endtask

    task automatic shift_ops();
        start_test();
        check_shift_sa("sll", FN_SLL, ALU_SLL, 5'd5, 5'd18, 5'd7);
        check_shift_sa("srl", FN_SRL, ALU_SRL, 5'd6, 5'd18, 5'd31);
        check_shift_sa("sra", FN_SRA, ALU_SRA, 5'd2, 5'd19, 5'd16);
        check_reg_reg("sllv", FN_SLLV, ALU_SLL, RES_SHIFT, 5'd1, 5'd2, 5'd19);
        check_reg_reg("srlv", FN_SRLV, ALU_SRL, RES_SHIFT, 5'd3, 5'd4, 5'd20);
        check_reg_reg("srav", FN_SRAV, ALU_SRA, RES_SHIFT, 5'd5, 5'd6, 5'd21);
        report_test("shift_ops");
    endtask

    task automatic forwarding_paths();
        word_t ex_data;
        word_t mem_data;
        word_t wt_data;
        start_test();
        ex_data  = $random(seed);
        mem_data = $random(seed);
        wt_data  = $random(seed);
        issue(r_format(5'd4, 5'd5, 5'd21, 5'd0, FN_ADD), 1'b1, 5'd4, ex_data, 1'b1, 5'd4, mem_data);
        check_outputs("ex over mem", ALU_ADD, RES_ARITH, 5'd21, 1'b1, ex_data, model_regs[5]);
        issue(r_format(5'd4, 5'd5, 5'd21, 5'd0, FN_ADD), 1'b1, 5'd4, ex_data, 1'b1, 5'd5, mem_data);
        check_outputs("ex and mem", ALU_ADD, RES_ARITH, 5'd21, 1'b1, ex_data, mem_data);
        issue(r_format(5'd4, 5'd5, 5'd21, 5'd0, FN_ADD), 1'b1, 5'd9, ex_data, 1'b1, 5'd4, mem_data);
        check_outputs("mem only", ALU_ADD, RES_ARITH, 5'd21, 1'b1, mem_data, model_regs[5]);
        issue(r_format(5'd4, 5'd5, 5'd21, 5'd0, FN_ADD), 1'b0, 5'd4, ex_data, 1'b0, 5'd5, mem_data);
        check_outputs("disabled", ALU_ADD, RES_ARITH, 5'd21, 1'b1, model_regs[4], model_regs[5]);
        issue(r_format(5'd4, 5'd5, 5'd21, 5'd0, FN_ADD), 1'b1, 5'd5, ex_data, 1'b0, 5'd0, mem_data);
        check_outputs("ex on rt", ALU_ADD, RES_ARITH, 5'd21, 1'b1, model_regs[4], ex_data);
        // Writeback in the same cycle as the read
        @(posedge clk);
        inst_i     <= r_format(5'd22, 5'd4, 5'd23, 5'd0, FN_OR);
        ex_wreg_i  <= 1'b0;
        mem_wreg_i <= 1'b0;
        wb_we_i    <= 1'b1;
        wb_addr_i  <= 5'd22;
        wb_data_i  <= wt_data;
        @(negedge clk);
        check_outputs("write-through", ALU_OR, RES_LOGIC, 5'd23, 1'b1, wt_data, model_regs[4]);
        @(posedge clk);
        wb_we_i <= 1'b0;
        model_regs[22] = wt_data;
        @(negedge clk);
        check_outputs("after write", ALU_OR, RES_LOGIC, 5'd23, 1'b1, wt_data, model_regs[4]);
        report_test("forwarding_paths");
    endtask

    task automatic moves_and_invalid();
        start_test();
        apply_inst(r_format(5'd1, 5'd2, 5'd24, 5'd0, FN_MOVN));
        check_move("movn reg", 1'b1, 5'd1, 5'd2, 5'd24);
        apply_inst(r_format(5'd1, NOP_REG_ADDR, 5'd24, 5'd0, FN_MOVN));
        check_move("movn zero", 1'b1, 5'd1, NOP_REG_ADDR, 5'd24);
        apply_inst(r_format(5'd2, NOP_REG_ADDR, 5'd25, 5'd0, FN_MOVZ));
        check_move("movz zero", 1'b0, 5'd2, NOP_REG_ADDR, 5'd25);
        issue(r_format(5'd2, 5'd3, 5'd25, 5'd0, FN_MOVZ), 1'b1, 5'd3, 32'h8000_0000,
              1'b0, '0, '0);
        check_move("movz nonzero", 1'b0, 5'd2, 5'd3, 5'd25);
        issue(r_format(5'd2, 5'd3, 5'd25, 5'd0, FN_MOVZ), 1'b1, 5'd3, '0, 1'b0, '0, '0);
        check_move("movz ex fwd", 1'b0, 5'd2, 5'd3, 5'd25);
        issue(r_format(5'd2, 5'd3, 5'd26, 5'd0, FN_MOVN), 1'b0, '0, '0, 1'b1, 5'd3, 32'h1);
        check_move("movn mem fwd", 1'b1, 5'd2, 5'd3, 5'd26);
        apply_inst(i_format(6'b111111, 5'd1, 5'd2, 16'h1234));
        check_outputs("bad opcode", ALU_NOP, RES_NOP, NOP_REG_ADDR, 1'b0, '0, '0);
        apply_inst(r_format(5'd1, 5'd2, 5'd3, 5'd0, 6'b111111));
        check_outputs("bad funct", ALU_NOP, RES_NOP, NOP_REG_ADDR, 1'b0, '0, '0);
        report_test("moves_and_invalid");
    endtask

`endif

/* testbench/tb_id_stage.sv */
`default_nettype none

module tb_id_stage
    import id_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 6;
    localparam int WATCHDOG_NS  = (NUM_TESTS * 40 + 100) * CLK_PERIOD;

    logic      clk;
    logic      reset_i;
    inst_t     inst_i;
    logic      wb_we_i;
    reg_addr_t wb_addr_i;
    word_t     wb_data_i;
    logic      ex_wreg_i;
    reg_addr_t ex_wd_i;
    word_t     ex_wdata_i;
    logic      mem_wreg_i;
    reg_addr_t mem_wd_i;
    word_t     mem_wdata_i;

    alu_op_t   aluop_o;
    alu_sel_t  alusel_o;
    word_t     reg1_o;
    word_t     reg2_o;
    reg_addr_t wd_o;
    logic      wreg_o;

    // Expected register contents, updated when a write commits
    word_t     model_regs [NUM_REGS];

    integer    seed = 68645;
    int        errors = 0;
    int        checks = 0;
    int        tests_run = 0;
    int        tests_failed = 0;
    int        errors_at_start = 0;

    id_stage i_id_stage (
        .clk         (clk),
        .reset_i     (reset_i),
        .inst_i      (inst_i),
        .wb_we_i     (wb_we_i),
        .wb_addr_i   (wb_addr_i),
        .wb_data_i   (wb_data_i),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .aluop_o     (aluop_o),
        .alusel_o    (alusel_o),
        .reg1_o      (reg1_o),
        .reg2_o      (reg2_o),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Instruction encoding and reference model
    // ------------------------------------------------------------------------
    function automatic inst_t r_format(input reg_addr_t rs, input reg_addr_t rt,
                                       input reg_addr_t rd, input logic [4:0] sa,
                                       input logic [5:0] funct);
        return {OP_SPECIAL, rs, rt, rd, sa, funct};
    endfunction

    function automatic inst_t i_format(input logic [5:0] op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Value of an enabled read, execute first, then memory, then the register file
    function automatic word_t expected_operand(input reg_addr_t addr);
        word_t value;
        if (ex_wreg_i && (ex_wd_i == addr)) begin
            value = ex_wdata_i;
        end else if (mem_wreg_i && (mem_wd_i == addr)) begin
            value = mem_wdata_i;
        end else if (addr == NOP_REG_ADDR) begin
            value = '0;
        end else if (wb_we_i && (wb_addr_i == addr)) begin
            value = wb_data_i;
        end else begin
            value = model_regs[addr];
        end
        return value;
    endfunction

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(posedge clk);
        wb_we_i   <= 1'b1;
        wb_addr_i <= addr;
        wb_data_i <= data;
        @(posedge clk);
        wb_we_i   <= 1'b0;
        if (addr != NOP_REG_ADDR) begin
            model_regs[addr] = data;
        end
    endtask

    // One instruction per cycle, outputs sampled at the falling edge
    task automatic issue(input inst_t inst,
                         input logic ex_we, input reg_addr_t ex_addr, input word_t ex_data,
                         input logic mem_we, input reg_addr_t mem_addr, input word_t mem_data);
        @(posedge clk);
        inst_i      <= inst;
        ex_wreg_i   <= ex_we;
        ex_wd_i     <= ex_addr;
        ex_wdata_i  <= ex_data;
        mem_wreg_i  <= mem_we;
        mem_wd_i    <= mem_addr;
        mem_wdata_i <= mem_data;
        @(negedge clk);
    endtask

    task automatic apply_inst(input inst_t inst);
        issue(inst, 1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic check_outputs(input string tag, input alu_op_t exp_op,
                                 input alu_sel_t exp_sel, input reg_addr_t exp_wd,
                                 input logic exp_wreg, input word_t exp_reg1,
                                 input word_t exp_reg2);
        checks += 6;
        assert (aluop_o === exp_op) else begin
            $display("[ERROR] %0d ns %s: aluop_o %h, expected %h", $time, tag, aluop_o, exp_op);
            errors++;
        end
        assert (alusel_o === exp_sel) else begin
            $display("[ERROR] %0d ns %s: alusel_o %h, expected %h",
                     $time, tag, alusel_o, exp_sel);
            errors++;
        end
        assert (wd_o === exp_wd) else begin
            $display("[ERROR] %0d ns %s: wd_o %0d, expected %0d", $time, tag, wd_o, exp_wd);
            errors++;
        end
        assert (wreg_o === exp_wreg) else begin
            $display("[ERROR] %0d ns %s: wreg_o %b, expected %b", $time, tag, wreg_o, exp_wreg);
            errors++;
        end
        assert (reg1_o === exp_reg1) else begin
            $display("[ERROR] %0d ns %s: reg1_o %h, expected %h", $time, tag, reg1_o, exp_reg1);
            errors++;
        end
        assert (reg2_o === exp_reg2) else begin
            $display("[ERROR] %0d ns %s: reg2_o %h, expected %h", $time, tag, reg2_o, exp_reg2);
            errors++;
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %-20s ok", name);
        end else begin
            tests_failed++;
            $display("test %-20s FAIL (%0d errors)", name, errors - errors_at_start);
        end
    endtask

`include "id_tests.svh"

    initial begin
        reset_i     = 1'b1;
        inst_i      = '0;
        wb_we_i     = 1'b0;
        wb_addr_i   = '0;
        wb_data_i   = '0;
        ex_wreg_i   = 1'b0;
        ex_wd_i     = '0;
        ex_wdata_i  = '0;
        mem_wreg_i  = 1'b0;
        mem_wd_i    = '0;
        mem_wdata_i = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        reset_behavior();
        reg_reg_ops();
        immediate_ops();
        shift_ops();
        forwarding_paths();
        moves_and_invalid();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+testbench
rtl/id_pkg.sv
rtl/reg_file.sv
rtl/inst_decoder.sv
rtl/operand_forward.sv
rtl/id_stage.sv
testbench/tb_id_stage.sv
